// ==== vlog.f ====
+incdir+include
source/memory_pkg.sv
source/lowest_set_encoder.sv
source/dcache_wb_victim_buffer.sv
source/wbb_l2_requester.sv
source/dcache_wbb_top.sv
test/tb_dcache_wbb.sv

// ==== test/tb_dcache_wbb.sv ====
// Testbench for the L1 data cache write-back victim buffer
// Table-driven D1 ops, a behavioral L2 responder and a line data scoreboard

`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module tb_dcache_wbb;

  import memory_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_ROWS   = 23;
  // Cycles from grant release to the L2 answer
  localparam int ANS_DELAY  = 3;
  // Longest wait for a ready level or a request
  localparam int WAIT_MAX   = 20;

  // L2 action of a table row
  localparam logic [1:0] L2_NONE = 2'd0;
  localparam logic [1:0] L2_GNT  = 2'd1;
  localparam logic [1:0] L2_ANS  = 2'd2;
  localparam logic [1:0] L2_BOTH = 2'd3;

  // One stimulus row with its expected lookup result
  typedef struct packed {
    wbb_op_e           op;
    line_addr_t        addr;
    logic [1:0]        l2_act;
    logic [3:0]        gnt_delay;
    logic              ans_ok;
    line_addr_t        req_addr;
    logic              exp_hit;
    wbb_free_entries_t exp_free;
  } row_t;

  // One granted L2 request
  typedef struct packed {
    line_addr_t   addr;
    dcache_line_t line;
    wbb_tag_t     tag;
  } l2_txn_t;

  logic              clk_i;
  logic              rst_ni;
  wbb_op_e           d1_op_i;
  dcache_line_t      d1_line_i;
  line_addr_t        d1_line_addr_i;
  logic              d1_ready_o;
  logic              d1_hit_o;
  dcache_line_t      d1_line_o;
  logic              l2_gnt_i;
  logic              l2_ans_i;
  logic              l2_ans_ok_i;
  wbb_tag_t          l2_ans_tag_i;
  logic              l2_req_o;
  dcache_line_t      l2_line_o;
  line_addr_t        l2_line_addr_o;
  wbb_tag_t          l2_tag_o;
  wbb_free_entries_t free_entries_o;

  row_t         table_rows [NUM_ROWS];
  // Last line written per address
  dcache_line_t model_line [1 << `LINE_ADDR_BITS];
  l2_txn_t      sent_q [$];
  wbb_tag_t     exp_tag;
  logic [15:0]  lfsr;
  int           errors;
  int           checks;

  dcache_wbb_top UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .d1_op_i       (d1_op_i),
    .d1_line_i     (d1_line_i),
    .d1_line_addr_i(d1_line_addr_i),
    .d1_ready_o    (d1_ready_o),
    .d1_hit_o      (d1_hit_o),
    .d1_line_o     (d1_line_o),
    .l2_gnt_i      (l2_gnt_i),
    .l2_ans_i      (l2_ans_i),
    .l2_ans_ok_i   (l2_ans_ok_i),
    .l2_ans_tag_i  (l2_ans_tag_i),
    .l2_req_o      (l2_req_o),
    .l2_line_o     (l2_line_o),
    .l2_line_addr_o(l2_line_addr_o),
    .l2_tag_o      (l2_tag_o),
    .free_entries_o(free_entries_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
  endfunction

  // One LFSR step per data bit
  function automatic dcache_line_t random_line();
    dcache_line_t line;
    line = '0;
    for (int i = 0; i < `LINE_BITS; i++) begin
      lfsr = lfsr_step(lfsr);
      line[i] = lfsr[0];
    end
    return line;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic ok, input string msg);
    checks++;
    assert (ok === 1'b1) else begin
      errors++;
      $display("ERROR %0t ns: %s", $time, msg);
    end
  endtask

  task automatic add_row(input int idx, input wbb_op_e op, input line_addr_t addr,
                         input logic [1:0] act, input int dly, input logic ok,
                         input line_addr_t req, input logic hit, input int free);
    table_rows[idx].op        = op;
    table_rows[idx].addr      = addr;
    table_rows[idx].l2_act    = act;
    table_rows[idx].gnt_delay = 4'(dly);
    table_rows[idx].ans_ok    = ok;
    table_rows[idx].req_addr  = req;
    table_rows[idx].exp_hit   = hit;
    table_rows[idx].exp_free  = wbb_free_entries_t'(free);
  endtask

  // op, address, L2 action, grant delay, answer ok, requested address, hit, free
  task automatic fill_table();
    // Fill all four entries, then a dropped evict
    add_row(0,  WBB_EVICT,   12'h100, L2_NONE, 0, 1'b0, 12'h000, 1'b1, 3);
    add_row(1,  WBB_EVICT,   12'h104, L2_NONE, 0, 1'b0, 12'h000, 1'b1, 2);
    add_row(2,  WBB_EVICT,   12'h208, L2_NONE, 0, 1'b0, 12'h000, 1'b1, 1);
    add_row(3,  WBB_EVICT,   12'h30c, L2_NONE, 0, 1'b0, 12'h000, 1'b1, 0);
    add_row(4,  WBB_EVICT,   12'h410, L2_NONE, 0, 1'b0, 12'h000, 1'b0, 0);
    // Drain in eviction order with one retry on the third line
    add_row(5,  WBB_NOP,     12'h100, L2_BOTH, 2, 1'b1, 12'h100, 1'b0, 1);
    add_row(6,  WBB_NOP,     12'h104, L2_BOTH, 0, 1'b1, 12'h104, 1'b0, 2);
    add_row(7,  WBB_NOP,     12'h208, L2_BOTH, 3, 1'b0, 12'h208, 1'b1, 2);
    add_row(8,  WBB_NOP,     12'h208, L2_BOTH, 1, 1'b1, 12'h208, 1'b0, 3);
    // New data for the last line before it is sent
    add_row(9,  WBB_SWITCH,  12'h30c, L2_NONE, 0, 1'b0, 12'h000, 1'b1, 3);
    add_row(10, WBB_NOP,     12'h30c, L2_BOTH, 0, 1'b1, 12'h30c, 1'b0, 4);
    // Reclaim while waiting for L2 so the late answer is dropped
    add_row(11, WBB_EVICT,   12'h520, L2_GNT,  1, 1'b0, 12'h520, 1'b1, 3);
    add_row(12, WBB_RECLAIM, 12'h520, L2_NONE, 0, 1'b0, 12'h000, 1'b0, 4);
    add_row(13, WBB_NOP,     12'h520, L2_ANS,  0, 1'b1, 12'h000, 1'b0, 4);
    // Reclaim and switch on a miss
    add_row(14, WBB_RECLAIM, 12'h410, L2_NONE, 0, 1'b0, 12'h000, 1'b0, 4);
    add_row(15, WBB_SWITCH,  12'h100, L2_NONE, 0, 1'b0, 12'h000, 1'b0, 4);
    // Tag counter wraps past 7
    add_row(16, WBB_EVICT,   12'h100, L2_NONE, 0, 1'b0, 12'h000, 1'b1, 3);
    add_row(17, WBB_NOP,     12'h100, L2_BOTH, 2, 1'b1, 12'h100, 1'b0, 4);
    add_row(18, WBB_EVICT,   12'h104, L2_BOTH, 0, 1'b1, 12'h104, 1'b0, 4);
    add_row(19, WBB_EVICT,   12'h208, L2_BOTH, 1, 1'b0, 12'h208, 1'b1, 3);
    add_row(20, WBB_NOP,     12'h208, L2_BOTH, 0, 1'b1, 12'h208, 1'b0, 4);
    // Reclaim of a line not yet granted
    add_row(21, WBB_EVICT,   12'h30c, L2_NONE, 0, 1'b0, 12'h000, 1'b1, 3);
    add_row(22, WBB_RECLAIM, 12'h30c, L2_NONE, 0, 1'b0, 12'h000, 1'b0, 4);
  endtask

  // Hold the op until a rising edge sees ready
  task automatic apply_d1_op(input wbb_op_e op, input dcache_line_t line,
                             input line_addr_t addr);
    int waited;
    waited = 0;
    @(negedge clk_i);
    d1_op_i        = op;
    d1_line_i      = line;
    d1_line_addr_i = addr;
    #1;
    while (!d1_ready_o && waited < WAIT_MAX) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    check_true(d1_ready_o, "D1 side never became ready");
    @(negedge clk_i);
    d1_op_i = WBB_NOP;
  endtask

  // Wait for the request, hold the grant back, then check what L2 gets
  task automatic grant_request(input int delay, input line_addr_t exp_addr);
    int      waited;
    l2_txn_t txn;
    waited = 0;
    @(negedge clk_i);
    #1;
    while (!l2_req_o && waited < WAIT_MAX) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    check_true(l2_req_o, "no L2 request appeared");
    repeat (delay) @(negedge clk_i);
    @(negedge clk_i);
    check_value("l2_req_o", l2_req_o, 1'b1);
    check_value("l2_line_addr_o", l2_line_addr_o, exp_addr);
    check_value("l2_line_o", l2_line_o, model_line[exp_addr]);
    // Tags count up by one per request modulo 8
    check_value("l2_tag_o", l2_tag_o, exp_tag);
    txn.addr = l2_line_addr_o;
    txn.line = l2_line_o;
    txn.tag  = l2_tag_o;
    sent_q.push_back(txn);
    exp_tag  = exp_tag + 1'b1;
    l2_gnt_i = 1'b1;
    #1;
    // D1 is held off while the grant owns the buffer
    check_value("d1_ready_o", d1_ready_o, 1'b0);
    @(negedge clk_i);
    l2_gnt_i = 1'b0;
  endtask

  // One answer pulse for the oldest granted request
  task automatic send_answer(input logic ok);
    l2_txn_t txn;
    if (sent_q.size() == 0) begin
      check_true(1'b0, "L2 answer requested with no request outstanding");
    end else begin
      txn = sent_q.pop_front();
      repeat (ANS_DELAY) @(negedge clk_i);
      l2_ans_i     = 1'b1;
      l2_ans_ok_i  = ok;
      l2_ans_tag_i = txn.tag;
      #1;
      // No D1 op in the answer cycle either
      check_value("d1_ready_o", d1_ready_o, 1'b0);
      @(negedge clk_i);
      l2_ans_i    = 1'b0;
      l2_ans_ok_i = 1'b0;
    end
  endtask

  task automatic lookup_check(input line_addr_t addr, input logic exp_hit,
                              input wbb_free_entries_t exp_free);
    @(negedge clk_i);
    d1_op_i        = WBB_NOP;
    d1_line_addr_i = addr;
    #1;
    check_value("d1_hit_o", d1_hit_o, exp_hit);
    if (exp_hit) begin
      check_value("d1_line_o", d1_line_o, model_line[addr]);
    end
    check_value("free_entries_o", free_entries_o, exp_free);
  endtask

  task automatic run_row(input row_t row);
    dcache_line_t line;
    line = '0;
    if (row.op == WBB_EVICT || row.op == WBB_SWITCH) begin
      line = random_line();
      // A dropped op leaves an address that never hits
      model_line[row.addr] = line;
    end
    if (row.op != WBB_NOP) begin
      apply_d1_op(row.op, line, row.addr);
    end
    if (row.l2_act == L2_GNT || row.l2_act == L2_BOTH) begin
      grant_request(row.gnt_delay, row.req_addr);
    end
    if (row.l2_act == L2_ANS || row.l2_act == L2_BOTH) begin
      send_answer(row.ans_ok);
    end
    lookup_check(row.addr, row.exp_hit, row.exp_free);
  endtask

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    d1_op_i        = WBB_NOP;
    d1_line_i      = '0;
    d1_line_addr_i = '0;
    l2_gnt_i       = 1'b0;
    l2_ans_i       = 1'b0;
    l2_ans_ok_i    = 1'b0;
    l2_ans_tag_i   = '0;
    lfsr           = 16'd8;
    exp_tag        = '0;
    errors         = 0;
    checks         = 0;
    fill_table();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    // Idle state out of reset
    check_value("l2_req_o", l2_req_o, 1'b0);
    check_value("d1_ready_o", d1_ready_o, 1'b1);
    check_value("d1_hit_o", d1_hit_o, 1'b0);
    check_value("free_entries_o", free_entries_o, `WBB_ENTRIES);
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(table_rows[r]);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Upper bound of 40 cycles per row
  initial begin
    #(NUM_ROWS * 40 * CLK_PERIOD);
    $display("ERROR %0t ns: watchdog expired before the table finished", $time);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/dcache_wbb_top.sv ====
// Write-back victim buffer top level
// Connects the victim buffer and its L2 requester to the D1 and L2 ports

`timescale 1ns/100ps
`default_nettype none

module dcache_wbb_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // D1 side
  input  memory_pkg::wbb_op_e           d1_op_i,
  input  memory_pkg::dcache_line_t      d1_line_i,
  input  memory_pkg::line_addr_t        d1_line_addr_i,
  output logic                          d1_ready_o,
  output logic                          d1_hit_o,
  output memory_pkg::dcache_line_t      d1_line_o,
  // L2 side
  input  logic                          l2_gnt_i,
  input  logic                          l2_ans_i,
  input  logic                          l2_ans_ok_i,
  input  memory_pkg::wbb_tag_t          l2_ans_tag_i,
  output logic                          l2_req_o,
  output memory_pkg::dcache_line_t      l2_line_o,
  output memory_pkg::line_addr_t        l2_line_addr_o,
  output memory_pkg::wbb_tag_t          l2_tag_o,
  output memory_pkg::wbb_free_entries_t free_entries_o
);

  import memory_pkg::*;

  // Strobes and compare inputs
  logic       add_line_addr;
  logic       put_wait_tag_read_line;
  logic       clr_hit_line;
  logic       switch_hit_line;
  logic       wup_hit_line;
  wbb_tag_t   cmp_tag;
  line_addr_t cmp_line_addr;
  // Buffer status
  logic       tag_hit;
  logic       req_available;
  logic       full;

  // The issued tag goes to L2 and into the granted entry
  wbb_l2_requester i_requester (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .d1_op_i                 (d1_op_i),
    .d1_line_addr_i          (d1_line_addr_i),
    .line_hit_i              (d1_hit_o),
    .tag_hit_i               (tag_hit),
    .req_available_i         (req_available),
    .full_i                  (full),
    .l2_gnt_i                (l2_gnt_i),
    .l2_ans_i                (l2_ans_i),
    .l2_ans_ok_i             (l2_ans_ok_i),
    .l2_ans_tag_i            (l2_ans_tag_i),
    .wbb_line_addr_i         (l2_line_addr_o),
    .add_line_addr_o         (add_line_addr),
    .put_wait_tag_read_line_o(put_wait_tag_read_line),
    .clr_hit_line_o          (clr_hit_line),
    .switch_hit_line_o       (switch_hit_line),
    .wup_hit_line_o          (wup_hit_line),
    .new_tag_o               (l2_tag_o),
    .cmp_tag_o               (cmp_tag),
    .cmp_line_addr_o         (cmp_line_addr),
    .d1_ready_o              (d1_ready_o),
    .l2_req_o                (l2_req_o)
  );

  dcache_wb_victim_buffer i_buffer (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .add_line_addr_i         (add_line_addr),
    .put_wait_tag_read_line_i(put_wait_tag_read_line),
    .clr_hit_line_i          (clr_hit_line),
    .switch_hit_line_i       (switch_hit_line),
    .wup_hit_line_i          (wup_hit_line),
    .new_tag_i               (l2_tag_o),
    .line_i                  (d1_line_i),
    .line_addr_i             (cmp_line_addr),
    .tag_to_be_compared_i    (cmp_tag),
    .wbb_l2c_line_o          (l2_line_o),
    .wbb_l2c_line_addr_o     (l2_line_addr_o),
    .wbb_d1_line_o           (d1_line_o),
    .line_hit_o              (d1_hit_o),
    .tag_hit_o               (tag_hit),
    .req_available_o         (req_available),
    .full_o                  (full),
    .free_entries_o          (free_entries_o)
  );

endmodule

`default_nettype wire

// ==== source/wbb_l2_requester.sv ====
// Victim buffer L2 requester
// Sequences one L2 write transaction at a time and turns D1 opcodes,
// L2 grants and L2 answers into buffer strobes

`timescale 1ns/100ps
`default_nettype none

module wbb_l2_requester (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // D1 side
  input  memory_pkg::wbb_op_e    d1_op_i,
  input  memory_pkg::line_addr_t d1_line_addr_i,
  // Buffer status
  input  logic                   line_hit_i,
  input  logic                   tag_hit_i,
  input  logic                   req_available_i,
  input  logic                   full_i,
  // L2 side
  input  logic                   l2_gnt_i,
  input  logic                   l2_ans_i,
  input  logic                   l2_ans_ok_i,
  input  memory_pkg::wbb_tag_t   l2_ans_tag_i,
  // Address of the entry currently offered to L2
  input  memory_pkg::line_addr_t wbb_line_addr_i,
  // Buffer strobes
  output logic                   add_line_addr_o,
  output logic                   put_wait_tag_read_line_o,
  output logic                   clr_hit_line_o,
  output logic                   switch_hit_line_o,
  output logic                   wup_hit_line_o,
  // Tags and compare address
  output memory_pkg::wbb_tag_t   new_tag_o,
  output memory_pkg::wbb_tag_t   cmp_tag_o,
  output memory_pkg::line_addr_t cmp_line_addr_o,
  output logic                   d1_ready_o,
  output logic                   l2_req_o
);

  import memory_pkg::*;

  req_state_e state_q;
  req_state_e state_d;
  wbb_tag_t   tag_cnt_q;
  line_addr_t out_addr_q;
  logic       grant;
  logic       ans_cycle;

  // Request only while an entry is there to send
  assign l2_req_o  = (state_q == REQ_SEND) && req_available_i;
  assign grant     = l2_req_o && l2_gnt_i;
  assign ans_cycle = (state_q == REQ_WAIT) && l2_ans_i;

  // L2 events own the buffer in their cycle
  assign d1_ready_o = !(l2_gnt_i || l2_ans_i);

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      REQ_IDLE: begin
        if (req_available_i) begin
          state_d = REQ_SEND;
        end
      end
      REQ_SEND: begin
        if (grant) begin
          state_d = REQ_WAIT;
        end else if (!req_available_i) begin
          // Entry reclaimed by D1 before the grant
          state_d = REQ_IDLE;
        end
      end
      REQ_WAIT: begin
        if (l2_ans_i) begin
          state_d = REQ_IDLE;
        end
      end
      default: state_d = REQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= REQ_IDLE;
      tag_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (grant) begin
        tag_cnt_q <= tag_cnt_q + 1'b1;
      end
    end
  end

  // Address of the outstanding line, compared again in the answer cycle
  always_ff @(posedge clk_i) begin
    if (grant) begin
      out_addr_q <= wbb_line_addr_i;
    end
  end

  assign new_tag_o = tag_cnt_q;

  // Outside the answer cycle compare against the next unissued tag
  // The only waiting entry holds the previous one, so no false tag hit
  assign cmp_tag_o       = ans_cycle ? l2_ans_tag_i : tag_cnt_q;
  assign cmp_line_addr_o = ans_cycle ? out_addr_q : d1_line_addr_i;

  // Strobes, L2 events first, D1 only when ready
  always_comb begin
    add_line_addr_o          = 1'b0;
    put_wait_tag_read_line_o = 1'b0;
    clr_hit_line_o           = 1'b0;
    switch_hit_line_o        = 1'b0;
    wup_hit_line_o           = 1'b0;
    if (grant) begin
      put_wait_tag_read_line_o = 1'b1;
    end else if (ans_cycle) begin
      // Stale tag means the line is gone, answer dropped
      clr_hit_line_o = tag_hit_i && l2_ans_ok_i;
      wup_hit_line_o = tag_hit_i && !l2_ans_ok_i;
    end else if (d1_ready_o) begin
      unique case (d1_op_i)
        WBB_EVICT:   add_line_addr_o   = !full_i;
        WBB_RECLAIM: clr_hit_line_o    = line_hit_i;
        WBB_SWITCH:  switch_hit_line_o = line_hit_i;
        default:     add_line_addr_o   = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/dcache_wb_victim_buffer.sv ====
// Write-back victim buffer register file
// Holds evicted dirty lines with valid and wait bits until L2 takes them,
// and compares D1 addresses and L2 answer tags against every entry

`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_wb_victim_buffer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Strobes from the requester, at most one per cycle
  input  logic                          add_line_addr_i,
  input  logic                          put_wait_tag_read_line_i,
  input  logic                          clr_hit_line_i,
  input  logic                          switch_hit_line_i,
  input  logic                          wup_hit_line_i,
  // Tag given to the entry sent to L2
  input  memory_pkg::wbb_tag_t          new_tag_i,
  // Line written on evict or switch
  input  memory_pkg::dcache_line_t      line_i,
  // Written on evict or switch, and compared every cycle
  input  memory_pkg::line_addr_t        line_addr_i,
  input  memory_pkg::wbb_tag_t          tag_to_be_compared_i,
  // Next entry to send to L2
  output memory_pkg::dcache_line_t      wbb_l2c_line_o,
  output memory_pkg::line_addr_t        wbb_l2c_line_addr_o,
  // Data of the entry that hit
  output memory_pkg::dcache_line_t      wbb_d1_line_o,
  // Status
  output logic                          line_hit_o,
  output logic                          tag_hit_o,
  output logic                          req_available_o,
  output logic                          full_o,
  output memory_pkg::wbb_free_entries_t free_entries_o
);

  import memory_pkg::*;

  localparam int WBB_ENTRIES = `WBB_ENTRIES;
  localparam int IDX_BITS    = (WBB_ENTRIES > 1) ? $clog2(WBB_ENTRIES) : 1;

  // Entry payload
  dcache_line_t line_q      [WBB_ENTRIES];
  line_addr_t   line_addr_q [WBB_ENTRIES];
  wbb_tag_t     tag_q       [WBB_ENTRIES];

  // Entry state
  // valid: holds a line, wait: sent to L2 and answer pending
  logic [WBB_ENTRIES-1:0] valid_q;
  logic [WBB_ENTRIES-1:0] wait_q;

  // Per-entry compare results
  logic [WBB_ENTRIES-1:0] line_hit_vec;
  logic [WBB_ENTRIES-1:0] tag_hit_vec;
  logic [WBB_ENTRIES-1:0] hit_vec;
  logic [WBB_ENTRIES-1:0] free_vec;
  logic [WBB_ENTRIES-1:0] ready_vec;

  // Selected entries
  logic [IDX_BITS-1:0] new_idx;
  logic [IDX_BITS-1:0] req_idx;
  logic [IDX_BITS-1:0] hit_idx;
  logic                free_found;
  logic                req_found;
  logic                hit_found;

  // Valid and wait bits, strobes in priority order
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      wait_q  <= '0;
    end else if (add_line_addr_i) begin
      valid_q[new_idx] <= 1'b1;
      wait_q[new_idx]  <= 1'b0;
    end else if (put_wait_tag_read_line_i) begin
      wait_q[req_idx] <= 1'b1;
    end else if (clr_hit_line_i) begin
      valid_q[hit_idx] <= 1'b0;
      wait_q[hit_idx]  <= 1'b0;
    end else if (switch_hit_line_i) begin
      // New victim at the same entry, goes back to the send queue
      wait_q[hit_idx] <= 1'b0;
    end else if (wup_hit_line_i) begin
      // Retry from L2, send again
      wait_q[hit_idx] <= 1'b0;
    end
  end

  // Payload, same priority as the state bits
  always_ff @(posedge clk_i) begin
    if (add_line_addr_i) begin
      line_q[new_idx]      <= line_i;
      line_addr_q[new_idx] <= line_addr_i;
    end else if (put_wait_tag_read_line_i) begin
      // Tag given at grant time
      tag_q[req_idx] <= new_tag_i;
    end else if (!clr_hit_line_i && switch_hit_line_i) begin
      line_q[hit_idx]      <= line_i;
      line_addr_q[hit_idx] <= line_addr_i;
    end
  end

  // Address compare only on valid entries
  // tag compare only on waiting ones, an old tag left in a free entry never hits
  always_comb begin
    for (int k = 0; k < WBB_ENTRIES; k++) begin
      line_hit_vec[k] = valid_q[k] && (line_addr_q[k] == line_addr_i);
      tag_hit_vec[k]  = wait_q[k] && (tag_q[k] == tag_to_be_compared_i);
    end
  end

  assign hit_vec   = line_hit_vec | tag_hit_vec;
  assign free_vec  = ~valid_q;
  assign ready_vec = valid_q & ~wait_q;

  // Where the next evict goes
  lowest_set_encoder #(
    .D(WBB_ENTRIES),
    .E(IDX_BITS)
  ) i_free_enc (
    .mh_decoded_i(free_vec),
    .oh_encoded_o(new_idx),
    .found_o     (free_found)
  );

  // Next entry offered to L2
  lowest_set_encoder #(
    .D(WBB_ENTRIES),
    .E(IDX_BITS)
  ) i_req_enc (
    .mh_decoded_i(ready_vec),
    .oh_encoded_o(req_idx),
    .found_o     (req_found)
  );

  // Entry hit by either compare
  lowest_set_encoder #(
    .D(WBB_ENTRIES),
    .E(IDX_BITS)
  ) i_hit_enc (
    .mh_decoded_i(hit_vec),
    .oh_encoded_o(hit_idx),
    .found_o     (hit_found)
  );

  // Output data
  assign wbb_l2c_line_o      = line_q[req_idx];
  assign wbb_l2c_line_addr_o = line_addr_q[req_idx];
  // Zero when nothing hit
  assign wbb_d1_line_o       = hit_found ? line_q[hit_idx] : '0;

  // Status
  assign line_hit_o      = |line_hit_vec;
  assign tag_hit_o       = |tag_hit_vec;
  assign req_available_o = req_found;
  assign full_o          = !free_found;

  // Count of invalid entries
  always_comb begin
    free_entries_o = '0;
    for (int k = 0; k < WBB_ENTRIES; k++) begin
      if (free_vec[k]) begin
        free_entries_o = free_entries_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/lowest_set_encoder.sv ====
// Lowest set bit encoder
// Returns the index of the lowest set bit and flags whether any bit is set

`timescale 1ns/100ps
`default_nettype none

module lowest_set_encoder #(
  parameter int D = 4,
  parameter int E = 2
) (
  input  logic [D-1:0] mh_decoded_i,
  output logic [E-1:0] oh_encoded_o,
  output logic         found_o
);

  // Scan from the top down so the lowest set bit wins
  // Index 0 when the vector is empty
  always_comb begin
    oh_encoded_o = '0;
    for (int i = D - 1; i >= 0; i--) begin
      if (mh_decoded_i[i]) begin
        oh_encoded_o = E'(i);
      end
    end
  end

  assign found_o = |mh_decoded_i;

endmodule

`default_nettype wire

// ==== source/memory_pkg.sv ====
// Shared types of the L1 data cache victim buffer
// Line, address, tag and count types, D1 opcodes and requester states

`default_nettype none

`include "dcache_macros.svh"

package memory_pkg;

  // One full cache line
  typedef logic [`LINE_BITS-1:0] dcache_line_t;

  // Line address as seen by D1 and L2
  typedef logic [`LINE_ADDR_BITS-1:0] line_addr_t;

  // L2 transaction tag
  typedef logic [`WBB_TAG_BITS-1:0] wbb_tag_t;

  // Free entry count, 0 up to the full depth
  typedef logic [$clog2(`WBB_ENTRIES):0] wbb_free_entries_t;

  // D1 opcode, one per cycle
  typedef enum logic [1:0] {
    WBB_NOP     = 2'b00,
    WBB_EVICT   = 2'b01,
    WBB_RECLAIM = 2'b10,
    WBB_SWITCH  = 2'b11
  } wbb_op_e;

  // L2 requester FSM states
  typedef enum logic [1:0] {
    REQ_IDLE = 2'b00,
    REQ_SEND = 2'b01,
    REQ_WAIT = 2'b10
  } req_state_e;

endpackage

`default_nettype wire

// ==== include/dcache_macros.svh ====
// Sizing of the L1 data cache write-back victim buffer
// Depth, line and address widths, and the L2 transaction tag width

`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Number of victim lines held at once
`define WBB_ENTRIES 4

// Width of one cache line in bits
`define LINE_BITS 64

// Line address, i.e. the byte address without the offset bits
`define LINE_ADDR_BITS 12

// L2 transaction tag, wraps around
// with a single outstanding request, 3 bits are plenty
`define WBB_TAG_BITS 3

`endif
